// ==== hdl/ethTxPkg.sv ====
package ethTxPkg;

    // one byte on the wire
    typedef logic [7:0] byteT;

    // lengths, counts and 16-bit header words
    typedef logic [15:0] lenT;

    // station addresses
    localparam logic [47:0] DEST_MAC = 48'h02_1A_2B_3C_4D_5E;
    localparam logic [47:0] SRC_MAC = 48'h02_00_5E_10_00_01;

    // IPv4 endpoints, 192.168.1.10 to 192.168.1.20
    localparam logic [31:0] SRC_IP = {8'd192, 8'd168, 8'd1, 8'd10};
    localparam logic [31:0] DEST_IP = {8'd192, 8'd168, 8'd1, 8'd20};

    // UDP ports
    localparam lenT SRC_PORT = 16'd5000;
    localparam lenT DEST_PORT = 16'd6000;

    // frame opening
    localparam byteT PREAMBLE_BYTE = 8'h55;
    localparam lenT PREAMBLE_COUNT = 16'd7;
    localparam byteT SFD_BYTE = 8'hD5;

    // MAC header
    localparam lenT ETHERTYPE_IPV4 = 16'h0800;
    localparam lenT MAC_HDR_LEN = 16'd14;

    // IPv4 header fields that never change
    localparam byteT IP_VER_IHL = 8'h45;
    localparam byteT IP_TOS = 8'h00;
    localparam lenT IP_FLAGS_FRAG = 16'h4000;
    localparam byteT IP_TTL = 8'h40;
    localparam byteT IP_PROTO_UDP = 8'h11;

    // header sizes in bytes
    localparam lenT IP_HDR_LEN = 16'd20;
    localparam lenT UDP_HDR_LEN = 16'd8;

    // frame check sequence
    localparam logic [31:0] CRC_POLY_REFLECTED = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;
    localparam lenT FCS_LEN = 16'd4;

    // quiet clocks kept after txEn drops
    localparam lenT IFG_CYCLES = 16'd48;

    // largest payload that still fits a 1500-byte IP packet
    localparam lenT MAX_PAYLOAD = 16'd1472;

endpackage

// ==== hdl/rmiiSerializer.sv ====
`timescale 1ns/10ps

module rmiiSerializer
    import ethTxPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       serEn,
    input  byteT       txByte,
    output logic [1:0] txd,
    output logic       txEn,
    output logic       byteTaken
);

    // upper three dibits of the byte in flight
    logic [5:0] restBits;
    // index of the dibit now on txd
    logic [1:0] phase;

    // take a byte when the line is idle or the last dibit is out
    assign byteTaken = serEn && (!txEn || phase == 2'd3);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            restBits <= '0;
            phase <= '0;
            txd <= '0;
            txEn <= 1'b0;
        end else if (byteTaken) begin
            // low pair goes out first
            txd <= txByte[1:0];
            restBits <= txByte[7:2];
            phase <= 2'd0;
            txEn <= 1'b1;
        end else if (txEn) begin
            if (phase == 2'd3) begin
                // nothing queued, release the line
                txEn <= 1'b0;
                txd <= 2'b00;
                phase <= 2'd0;
            end else begin
                txd <= restBits[1:0];
                restBits <= restBits >> 2;
                phase <= phase + 2'd1;
            end
        end
    end

endmodule

// ==== hdl/crc32Byte.sv ====
`timescale 1ns/10ps

module crc32Byte
    import ethTxPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        crcClear,
    input  logic        crcEn,
    input  byteT        dataByte,
    output logic [31:0] crcValue
);

    logic [31:0] crcReg;
    logic [31:0] crcNext;

    // bitwise reflected update, LSB of the byte first like the wire order
    always_comb begin
        crcNext = crcReg ^ {24'd0, dataByte};
        for (int i = 0; i < 8; i++) begin
            if (crcNext[0]) begin
                crcNext = (crcNext >> 1) ^ CRC_POLY_REFLECTED;
            end else begin
                crcNext = crcNext >> 1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            crcReg <= CRC_INIT;
        end else if (crcClear) begin
            // restart for a new frame
            crcReg <= CRC_INIT;
        end else if (crcEn) begin
            crcReg <= crcNext;
        end
    end

    // final complement, low byte goes out first
    assign crcValue = ~crcReg;

endmodule

// ==== hdl/ipv4Checksum.sv ====
`timescale 1ns/10ps

module ipv4Checksum
    import ethTxPkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic capture,
    input  lenT  totalLen,
    input  lenT  ipId,
    output lenT  hdrChecksum
);

    // ten words fit easily in 20 bits
    logic [19:0] wordSum;
    logic [16:0] foldOnce;
    lenT         foldTwice;

    always_comb begin
        // checksum word itself counts as zero
        wordSum = {4'd0, IP_VER_IHL, IP_TOS}
                + {4'd0, totalLen}
                + {4'd0, ipId}
                + {4'd0, IP_FLAGS_FRAG}
                + {4'd0, IP_TTL, IP_PROTO_UDP}
                + {4'd0, SRC_IP[31:16]}
                + {4'd0, SRC_IP[15:0]}
                + {4'd0, DEST_IP[31:16]}
                + {4'd0, DEST_IP[15:0]};
        // end-around carry needs a second fold when the first one carries
        foldOnce = {1'b0, wordSum[15:0]} + {13'd0, wordSum[19:16]};
        foldTwice = foldOnce[15:0] + {15'd0, foldOnce[16]};
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            hdrChecksum <= '0;
        end else if (capture) begin
            hdrChecksum <= ~foldTwice;
        end
    end

endmodule

// ==== hdl/frameSequencer.sv ====
`timescale 1ns/10ps

module frameSequencer
    import ethTxPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  lenT         dataLen,
    input  lenT         ipId,
    input  byteT        payloadByte,
    input  logic        byteTaken,
    input  logic [31:0] crcValue,
    input  lenT         hdrChecksum,
    output byteT        txByte,
    output logic        serEn,
    output logic        crcClear,
    output logic        crcEn,
    output logic        capture,
    output lenT         totalLen,
    output lenT         ipIdHeld,
    output logic        dataReq,
    output logic        busy
);

    enum logic [3:0] {
        S_IDLE, S_PREAMBLE, S_DELIM, S_MAC, S_IP, S_UDP, S_PAYLOAD, S_FCS, S_GAP
    } state, nextState;

    // byte index inside the current section, clock count in the gap
    lenT  idx;
    lenT  lastIdx;
    lenT  payloadLen;
    lenT  lenClamped;
    lenT  udpLen;
    logic startAccept;

    assign startAccept = (state == S_IDLE) && start;
    assign lenClamped = (dataLen > MAX_PAYLOAD) ? MAX_PAYLOAD : dataLen;
    assign udpLen = payloadLen + UDP_HDR_LEN;

    // frame fields held for the whole frame
    always_ff @(posedge clk) begin
        if (startAccept) begin
            payloadLen <= lenClamped;
            totalLen <= lenClamped + IP_HDR_LEN + UDP_HDR_LEN;
            ipIdHeld <= ipId;
        end
    end

    // section length and successor
    always_comb begin
        lastIdx = '0;
        nextState = S_IDLE;
        case (state)
            S_IDLE:     nextState = S_PREAMBLE;
            S_PREAMBLE: begin
                lastIdx = PREAMBLE_COUNT - 16'd1;
                nextState = S_DELIM;
            end
            S_DELIM:    nextState = S_MAC;
            S_MAC: begin
                lastIdx = MAC_HDR_LEN - 16'd1;
                nextState = S_IP;
            end
            S_IP: begin
                lastIdx = IP_HDR_LEN - 16'd1;
                nextState = S_UDP;
            end
            S_UDP: begin
                lastIdx = UDP_HDR_LEN - 16'd1;
                nextState = S_PAYLOAD;
            end
            S_PAYLOAD: begin
                lastIdx = payloadLen - 16'd1;
                nextState = S_FCS;
            end
            S_FCS: begin
                lastIdx = FCS_LEN - 16'd1;
                nextState = S_GAP;
            end
            // last byte still needs four dibit clocks before txEn drops
            S_GAP:      lastIdx = IFG_CYCLES + 16'd3;
            default:    nextState = S_IDLE;
        endcase
    end

    // byte offered to the serializer
    always_comb begin
        txByte = 8'h00;
        case (state)
            S_PREAMBLE: txByte = PREAMBLE_BYTE;
            S_DELIM:    txByte = SFD_BYTE;
            S_MAC: begin
                if (idx < 16'd6) begin
                    txByte = DEST_MAC[8 * (5 - idx[2:0]) +: 8];
                end else if (idx < 16'd12) begin
                    txByte = SRC_MAC[8 * (11 - idx[3:0]) +: 8];
                end else if (idx == 16'd12) begin
                    txByte = ETHERTYPE_IPV4[15:8];
                end else begin
                    txByte = ETHERTYPE_IPV4[7:0];
                end
            end
            S_IP: begin
                case (idx[4:0])
                    5'd0:    txByte = IP_VER_IHL;
                    5'd1:    txByte = IP_TOS;
                    5'd2:    txByte = totalLen[15:8];
                    5'd3:    txByte = totalLen[7:0];
                    5'd4:    txByte = ipIdHeld[15:8];
                    5'd5:    txByte = ipIdHeld[7:0];
                    5'd6:    txByte = IP_FLAGS_FRAG[15:8];
                    5'd7:    txByte = IP_FLAGS_FRAG[7:0];
                    5'd8:    txByte = IP_TTL;
                    5'd9:    txByte = IP_PROTO_UDP;
                    5'd10:   txByte = hdrChecksum[15:8];
                    5'd11:   txByte = hdrChecksum[7:0];
                    5'd12:   txByte = SRC_IP[31:24];
                    5'd13:   txByte = SRC_IP[23:16];
                    5'd14:   txByte = SRC_IP[15:8];
                    5'd15:   txByte = SRC_IP[7:0];
                    5'd16:   txByte = DEST_IP[31:24];
                    5'd17:   txByte = DEST_IP[23:16];
                    5'd18:   txByte = DEST_IP[15:8];
                    default: txByte = DEST_IP[7:0];
                endcase
            end
            S_UDP: begin
                case (idx[2:0])
                    3'd0:    txByte = SRC_PORT[15:8];
                    3'd1:    txByte = SRC_PORT[7:0];
                    3'd2:    txByte = DEST_PORT[15:8];
                    3'd3:    txByte = DEST_PORT[7:0];
                    3'd4:    txByte = udpLen[15:8];
                    3'd5:    txByte = udpLen[7:0];
                    // UDP checksum left at zero, which means unused
                    default: txByte = 8'h00;
                endcase
            end
            S_PAYLOAD:  txByte = payloadByte;
            S_FCS:      txByte = crcValue[8 * idx[1:0] +: 8];
            default:    txByte = 8'h00;
        endcase
    end

    assign crcClear = byteTaken && (state == S_DELIM);
    assign crcEn = byteTaken && (state inside {S_MAC, S_IP, S_UDP, S_PAYLOAD});
    assign dataReq = byteTaken && (state == S_PAYLOAD);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= S_IDLE;
            idx <= '0;
            serEn <= 1'b0;
            busy <= 1'b0;
            capture <= 1'b0;
        end else begin
            capture <= startAccept;
            case (state)
                S_IDLE: begin
                    if (startAccept) begin
                        state <= nextState;
                        idx <= '0;
                        serEn <= 1'b1;
                        busy <= 1'b1;
                    end
                end
                S_GAP: begin
                    if (idx == lastIdx) begin
                        state <= S_IDLE;
                        idx <= '0;
                        busy <= 1'b0;
                    end else begin
                        idx <= idx + 16'd1;
                    end
                end
                default: begin
                    if (byteTaken) begin
                        if (idx == lastIdx) begin
                            state <= nextState;
                            idx <= '0;
                            // last FCS byte handed over, serializer drains it
                            if (state == S_FCS) begin
                                serEn <= 1'b0;
                            end
                        end else begin
                            idx <= idx + 16'd1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

// ==== hdl/ethUdpTx.sv ====
`timescale 1ns/10ps

module ethUdpTx
    import ethTxPkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       start,
    input  lenT        dataLen,
    input  lenT        ipId,
    input  byteT       payloadByte,
    output logic       dataReq,
    output logic [1:0] txd,
    output logic       txEn,
    output logic       busy
);

    byteT        txByte;
    logic        serEn;
    logic        byteTaken;
    logic        crcClear;
    logic        crcEn;
    logic [31:0] crcValue;
    logic        capture;
    lenT         totalLen;
    lenT         ipIdHeld;
    lenT         hdrChecksum;

    frameSequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .dataLen     (dataLen),
        .ipId        (ipId),
        .payloadByte (payloadByte),
        .byteTaken   (byteTaken),
        .crcValue    (crcValue),
        .hdrChecksum (hdrChecksum),
        .txByte      (txByte),
        .serEn       (serEn),
        .crcClear    (crcClear),
        .crcEn       (crcEn),
        .capture     (capture),
        .totalLen    (totalLen),
        .ipIdHeld    (ipIdHeld),
        .dataReq     (dataReq),
        .busy        (busy)
    );

    rmiiSerializer u_serializer (
        .clk       (clk),
        .rst       (rst),
        .serEn     (serEn),
        .txByte    (txByte),
        .txd       (txd),
        .txEn      (txEn),
        .byteTaken (byteTaken)
    );

    // CRC sees exactly the byte the serializer latches
    crc32Byte u_crc (
        .clk      (clk),
        .rst      (rst),
        .crcClear (crcClear),
        .crcEn    (crcEn),
        .dataByte (txByte),
        .crcValue (crcValue)
    );

    ipv4Checksum u_checksum (
        .clk         (clk),
        .rst         (rst),
        .capture     (capture),
        .totalLen    (totalLen),
        .ipId        (ipIdHeld),
        .hdrChecksum (hdrChecksum)
    );

endmodule

// ==== bench/frameModel.svh ====
`ifndef FRAME_MODEL_SVH
`define FRAME_MODEL_SVH

// expected wire bytes of the frame under test
byteT expFrame[$];

// big-endian field, most significant byte first
function automatic void pushBytes(logic [47:0] value, int count);
    for (int i = count - 1; i >= 0; i--) begin
        expFrame.push_back(value[8 * i +: 8]);
    end
endfunction

function automatic lenT headerChecksum(int first);
    logic [31:0] sum;
    sum = '0;
    for (int i = first; i < first + IP_HDR_LEN; i += 2) begin
        sum = sum + {expFrame[i], expFrame[i + 1]};
    end
    // fold carries back in until none are left
    while (sum[31:16] != 16'd0) begin
        sum = {16'd0, sum[15:0]} + {16'd0, sum[31:16]};
    end
    return ~sum[15:0];
endfunction

function automatic logic [31:0] reverse32(logic [31:0] value);
    logic [31:0] result;
    for (int i = 0; i < 32; i++) begin
        result[i] = value[31 - i];
    end
    return result;
endfunction

// MSB-first shift register fed LSB first, reversed at the end
function automatic logic [31:0] crcOver(byteT data[$], int first);
    logic [31:0] poly;
    logic [31:0] shiftReg;
    logic        feedback;
    poly = reverse32(CRC_POLY_REFLECTED);
    shiftReg = CRC_INIT;
    for (int n = first; n < data.size(); n++) begin
        for (int b = 0; b < 8; b++) begin
            feedback = shiftReg[31] ^ data[n][b];
            shiftReg = {shiftReg[30:0], 1'b0};
            if (feedback) begin
                shiftReg = shiftReg ^ poly;
            end
        end
    end
    return ~reverse32(shiftReg);
endfunction

function automatic void buildFrame(lenT len, lenT id, byteT pay[$]);
    int          ipStart;
    lenT         sum;
    logic [31:0] fcs;
    expFrame.delete();
    repeat (PREAMBLE_COUNT) expFrame.push_back(PREAMBLE_BYTE);
    expFrame.push_back(SFD_BYTE);
    pushBytes(DEST_MAC, 6);
    pushBytes(SRC_MAC, 6);
    pushBytes(ETHERTYPE_IPV4, 2);
    ipStart = expFrame.size();
    pushBytes({IP_VER_IHL, IP_TOS}, 2);
    pushBytes(len + IP_HDR_LEN + UDP_HDR_LEN, 2);
    pushBytes(id, 2);
    pushBytes(IP_FLAGS_FRAG, 2);
    pushBytes({IP_TTL, IP_PROTO_UDP}, 2);
    // checksum slot stays zero while summing
    pushBytes(16'h0000, 2);
    pushBytes(SRC_IP, 4);
    pushBytes(DEST_IP, 4);
    sum = headerChecksum(ipStart);
    expFrame[ipStart + 10] = sum[15:8];
    expFrame[ipStart + 11] = sum[7:0];
    pushBytes(SRC_PORT, 2);
    pushBytes(DEST_PORT, 2);
    pushBytes(len + UDP_HDR_LEN, 2);
    pushBytes(16'h0000, 2);
    foreach (pay[i]) expFrame.push_back(pay[i]);
    // FCS covers everything after the delimiter
    fcs = crcOver(expFrame, PREAMBLE_COUNT + 1);
    for (int i = 0; i < 4; i++) begin
        expFrame.push_back(fcs[8 * i +: 8]);
    end
endfunction

`endif

// ==== bench/ethUdpTxTb.sv ====
`timescale 1ns/10ps

module ethUdpTxTb
    import ethTxPkg::*;
();

    logic        clk;
    logic        rst;
    logic        start;
    lenT         dataLen;
    lenT         ipId;
    byteT        payloadByte;
    logic        dataReq;
    logic [1:0]  txd;
    logic        txEn;
    logic        busy;

    logic [15:0] lfsrState;
    byteT        payload[$];
    byteT        gotFrame[$];
    int          payIdx;
    int          reqCount;
    int          frameCount;

    `include "frameModel.svh"

    ethUdpTx u_dut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .dataLen     (dataLen),
        .ipId        (ipId),
        .payloadByte (payloadByte),
        .dataReq     (dataReq),
        .txd         (txd),
        .txEn        (txEn),
        .busy        (busy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [15:0] takeBits(int count);
        logic [15:0] value;
        logic        feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], feedback};
            value = {value[14:0], feedback};
        end
        return value;
    endfunction

    task automatic stopOnError(string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkByte(string name, byteT got, byteT exp);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkLen(string name, lenT got, lenT exp);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp) begin
            stopOnError($sformatf("mismatch %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    // next payload byte appears right after each dataReq cycle
    initial begin : payloadSource
        logic reqSeen;
        forever begin
            @(negedge clk);
            reqSeen = dataReq;
            @(posedge clk);
            #1;
            if (reqSeen) begin
                reqCount++;
                payIdx++;
            end
            payloadByte = (payIdx < payload.size()) ? payload[payIdx] : 8'h00;
        end
    end

    // one frame per txEn burst with the low dibit first
    initial begin : dibitCapture
        byteT shifter;
        int   dibits;
        logic wasOn;
        shifter = '0;
        dibits = 0;
        wasOn = 1'b0;
        forever begin
            @(negedge clk);
            if (txEn) begin
                shifter = {txd, shifter[7:2]};
                dibits++;
                if (dibits == 4) begin
                    gotFrame.push_back(shifter);
                    dibits = 0;
                end
            end else if (wasOn) begin
                if (dibits != 0) begin
                    stopOnError("txEn dropped in the middle of a byte");
                end
                frameCount++;
            end
            wasOn = txEn;
        end
    end

    initial begin : stimulus
        lenT len;
        lenT id;
        int  timer;
        int  gapCount;
        rst = 1'b0;
        start = 1'b0;
        dataLen = '0;
        ipId = '0;
        payloadByte = '0;
        payIdx = 0;
        reqCount = 0;
        frameCount = 0;
        lfsrState = 16'd58;

        // model CRC against the standard "123456789" check value
        for (int i = 0; i < 9; i++) begin
            payload.push_back(8'h31 + i);
        end
        if (crcOver(payload, 0) !== 32'hCBF43926) begin
            stopOnError("reference CRC does not give the standard check value");
        end
        payload.delete();

        repeat (16) @(posedge clk);
        #1 rst = 1'b1;
        repeat (20) begin
            @(negedge clk);
            checkBit("busy", busy, 1'b0);
            checkBit("txEn", txEn, 1'b0);
            checkBit("dataReq", dataReq, 1'b0);
        end

        for (int f = 0; f < 8; f++) begin
            len = 16'd18 + takeBits(6) % 16'd47;
            id = takeBits(16);
            payload.delete();
            for (int i = 0; i < len; i++) begin
                payload.push_back(takeBits(8));
            end
            buildFrame(len, id, payload);
            gotFrame.delete();
            payIdx = 0;
            reqCount = 0;
            repeat (takeBits(3)) @(posedge clk);

            @(posedge clk);
            #1;
            start = 1'b1;
            dataLen = len;
            ipId = id;
            @(negedge clk);
            checkBit("busy", busy, 1'b0);
            @(posedge clk);
            #1;
            // these values must not reach the frame
            start = 1'b0;
            dataLen = takeBits(6);
            ipId = takeBits(16);
            @(negedge clk);
            checkBit("busy", busy, 1'b1);

            timer = 0;
            do begin
                @(negedge clk);
                timer++;
                if (timer > 100) begin
                    stopOnError("timeout waiting for txEn to rise");
                end
            end while (!txEn);

            // a start while busy must not produce a second frame
            @(posedge clk);
            #1 start = 1'b1;
            @(posedge clk);
            #1 start = 1'b0;

            timer = 0;
            do begin
                @(negedge clk);
                timer++;
                if (timer > 1000) begin
                    stopOnError("timeout waiting for txEn to fall");
                end
            end while (txEn);

            gapCount = 0;
            timer = 0;
            while (busy) begin
                checkBit("txEn", txEn, 1'b0);
                gapCount++;
                @(negedge clk);
                timer++;
                if (timer > 200) begin
                    stopOnError("timeout waiting for busy to fall");
                end
            end

            checkLen("busy cycles after txEn fell", gapCount, IFG_CYCLES);
            checkLen("dataReq count", reqCount, len);
            checkLen("frames seen on txd", frameCount, f + 1);
            checkLen("frame length", gotFrame.size(), len + 16'd54);
            for (int i = 0; i < expFrame.size(); i++) begin
                checkByte($sformatf("txd byte %0d of frame %0d", i, f),
                          gotFrame[i], expFrame[i]);
            end
        end

        // line stays quiet once the last frame is done
        repeat (20) begin
            @(negedge clk);
            checkBit("busy", busy, 1'b0);
            checkBit("txEn", txEn, 1'b0);
            checkBit("dataReq", dataReq, 1'b0);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+bench
hdl/ethTxPkg.sv
hdl/rmiiSerializer.sv
hdl/crc32Byte.sv
hdl/ipv4Checksum.sv
hdl/frameSequencer.sv
hdl/ethUdpTx.sv
bench/ethUdpTxTb.sv
